// File: rtl/atomics_pkg.sv
// ##########################################################
// Shared definitions of the atomics adapter
//   Bus widths, requester ID count and cut count
//   Opcode enum of the core-side bus
//   Request and response structs of the core and memory buses
// ##########################################################
package atomics_pkg;

    localparam int unsigned ADDR_W   = 16;
    localparam int unsigned DATA_W   = 32;
    localparam int unsigned ID_W     = 2;
    localparam int unsigned NUM_IDS  = 4;
    localparam int unsigned N_CUTS   = 2;
    localparam int unsigned WORD_LSB = 2;

    // Room for every request and response that the cuts and the table can hold at once
    localparam int unsigned PEND_W   = $clog2(2 * N_CUTS + 2) + 1;

    typedef enum logic [3:0] {
        op_load,
        op_store,
        op_lr,
        op_sc,
        op_amo_swap,
        op_amo_add,
        op_amo_and,
        op_amo_or,
        op_amo_xor,
        op_amo_max,
        op_amo_min,
        op_amo_maxu,
        op_amo_minu
    } bus_op_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        bus_op_e           op;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic [ID_W-1:0]   id;
    } bus_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

// File: rtl/amo_sequencer.sv
// ##########################################################
// AMO sequencer
//   Splits each AMO into a load, an ALU step and a store
//   Forwards load, store, LR and SC requests unchanged
// ##########################################################
module amo_sequencer (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  atomics_pkg::bus_req_t req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output atomics_pkg::bus_rsp_t rsp_o,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output atomics_pkg::bus_req_t fwd_req_o,
    output logic                  fwd_req_valid_o,
    input  logic                  fwd_req_ready_i,
    input  atomics_pkg::bus_rsp_t fwd_rsp_i,
    input  logic                  fwd_rsp_valid_i,
    output logic                  fwd_rsp_ready_o
);
    import atomics_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_compute,
        st_write,
        st_respond
    } state_e;

    state_e            state_q;
    logic              run_q;
    logic              issued_q;
    logic [PEND_W-1:0] pend_q;
    bus_req_t          amo_q;
    logic [DATA_W-1:0] old_q;
    logic [DATA_W-1:0] alu_res;
    logic              gt_s;
    logic              gt_u;
    logic              is_amo;
    logic              req_hs;
    logic              fwd_req_hs;
    logic              fwd_rsp_hs;

    assign is_amo     = !(req_i.op inside {op_load, op_store, op_lr, op_sc});
    assign req_hs     = req_valid_i && req_ready_o;
    assign fwd_req_hs = fwd_req_valid_o && fwd_req_ready_i;
    assign fwd_rsp_hs = fwd_rsp_valid_i && fwd_rsp_ready_o;

    always_comb begin
        fwd_req_o       = req_i;
        fwd_req_valid_o = 1'b0;
        req_ready_o     = 1'b0;
        rsp_o           = fwd_rsp_i;
        rsp_valid_o     = 1'b0;
        fwd_rsp_ready_o = 1'b0;
        case (state_q)
            st_idle: begin
                // An AMO is only taken once every forwarded request has been answered
                fwd_req_valid_o = run_q && req_valid_i && !is_amo;
                req_ready_o     = run_q && (is_amo ? (pend_q == '0) : fwd_req_ready_i);
                rsp_valid_o     = fwd_rsp_valid_i;
                fwd_rsp_ready_o = rsp_ready_i;
            end
            st_read, st_write: begin
                fwd_req_o.addr  = amo_q.addr;
                fwd_req_o.id    = amo_q.id;
                fwd_req_o.op    = (state_q == st_read) ? op_load : op_store;
                fwd_req_o.wdata = (state_q == st_read) ? '0 : amo_q.wdata;
                fwd_req_valid_o = !issued_q;
                fwd_rsp_ready_o = issued_q;
            end
            st_respond: begin
                rsp_o.rdata = old_q;
                rsp_o.id    = amo_q.id;
                rsp_valid_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign gt_s = $signed(old_q) > $signed(amo_q.wdata);
    assign gt_u = old_q > amo_q.wdata;

    always_comb begin
        case (amo_q.op)
            op_amo_add:  alu_res = old_q + amo_q.wdata;
            op_amo_and:  alu_res = old_q & amo_q.wdata;
            op_amo_or:   alu_res = old_q | amo_q.wdata;
            op_amo_xor:  alu_res = old_q ^ amo_q.wdata;
            op_amo_max:  alu_res = gt_s ? old_q : amo_q.wdata;
            op_amo_min:  alu_res = gt_s ? amo_q.wdata : old_q;
            op_amo_maxu: alu_res = gt_u ? old_q : amo_q.wdata;
            op_amo_minu: alu_res = gt_u ? amo_q.wdata : old_q;
            default:     alu_res = amo_q.wdata;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= st_idle;
            run_q    <= 1'b0;
            issued_q <= 1'b0;
            pend_q   <= '0;
        end else begin
            run_q <= 1'b1;
            case (state_q)
                st_idle: begin
                    pend_q <= pend_q + PEND_W'(fwd_req_hs) - PEND_W'(fwd_rsp_hs);
                    if (req_hs && is_amo) begin
                        state_q <= st_read;
                    end
                end
                st_read, st_write: begin
                    if (fwd_req_hs) begin
                        issued_q <= 1'b1;
                    end
                    if (fwd_rsp_hs) begin
                        issued_q <= 1'b0;
                        state_q  <= (state_q == st_read) ? st_compute : st_respond;
                    end
                end
                st_compute: begin
                    state_q <= st_write;
                end
                default: begin
                    if (rsp_ready_i) begin
                        state_q <= st_idle;
                    end
                end
            endcase
        end
    end

    // The operand register is reused for the value that the store writes back
    always_ff @(posedge clk_i) begin
        if (state_q == st_idle && req_hs && is_amo) begin
            amo_q <= req_i;
        end
        if (state_q == st_read && fwd_rsp_hs) begin
            old_q <= fwd_rsp_i.rdata;
        end
        if (state_q == st_compute) begin
            amo_q.wdata <= alu_res;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == st_read && fwd_req_valid_o) |-> (pend_q == '0));

endmodule

// File: rtl/bus_cut.sv
// ##########################################################
// Register cut on the core-side bus
//   One-entry request stage and one-entry response stage
// ##########################################################
module bus_cut (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  atomics_pkg::bus_req_t in_req_i,
    input  logic                  in_req_valid_i,
    output logic                  in_req_ready_o,
    output atomics_pkg::bus_req_t out_req_o,
    output logic                  out_req_valid_o,
    input  logic                  out_req_ready_i,
    input  atomics_pkg::bus_rsp_t out_rsp_i,
    input  logic                  out_rsp_valid_i,
    output logic                  out_rsp_ready_o,
    output atomics_pkg::bus_rsp_t in_rsp_o,
    output logic                  in_rsp_valid_o,
    input  logic                  in_rsp_ready_i
);

    // A stage takes a new item while it is empty or being drained
    assign in_req_ready_o  = !out_req_valid_o || out_req_ready_i;
    assign out_rsp_ready_o = !in_rsp_valid_o || in_rsp_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_req_valid_o <= 1'b0;
            in_rsp_valid_o  <= 1'b0;
        end else begin
            if (in_req_ready_o) begin
                out_req_valid_o <= in_req_valid_i;
            end
            if (out_rsp_ready_o) begin
                in_rsp_valid_o <= out_rsp_valid_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_req_valid_i && in_req_ready_o) begin
            out_req_o <= in_req_i;
        end
        if (out_rsp_valid_i && out_rsp_ready_o) begin
            in_rsp_o <= out_rsp_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        (out_req_valid_o && !out_req_ready_i) |=> $stable(out_req_o));

endmodule

// File: rtl/reservation_table.sv
// ##########################################################
// LR/SC reservation table
//   One reservation per requester ID on a word address
//   Decides SC success and issues one memory access at a time
// ##########################################################
module reservation_table (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  atomics_pkg::bus_req_t req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output atomics_pkg::bus_rsp_t rsp_o,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output atomics_pkg::mem_req_t mem_req_o,
    output logic                  mem_req_valid_o,
    input  logic                  mem_req_ready_i,
    input  atomics_pkg::mem_rsp_t mem_rsp_i,
    input  logic                  mem_rsp_valid_i,
    output logic                  mem_rsp_ready_o
);
    import atomics_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_mem,
        st_respond
    } state_e;

    state_e                     state_q;
    logic [ID_W-1:0]            id_q;
    logic                       we_q;
    logic [NUM_IDS-1:0]         res_valid_q;
    logic [ADDR_W-WORD_LSB-1:0] res_addr_q [NUM_IDS];
    logic [ADDR_W-WORD_LSB-1:0] req_word;
    logic                       own_hit;
    logic                       sc_fail;
    logic                       is_write;
    logic                       accept;

    assign req_word = req_i.addr[ADDR_W-1:WORD_LSB];
    assign own_hit  = res_valid_q[req_i.id] && (res_addr_q[req_i.id] == req_word);
    assign sc_fail  = (req_i.op == op_sc) && !own_hit;
    assign is_write = (req_i.op == op_store) || (req_i.op == op_sc);

    assign mem_req_o.addr  = req_i.addr;
    assign mem_req_o.we    = is_write;
    assign mem_req_o.wdata = req_i.wdata;
    assign mem_req_valid_o = (state_q == st_idle) && req_valid_i && !sc_fail;
    assign req_ready_o     = (state_q == st_idle) && (sc_fail || mem_req_ready_i);
    assign accept          = req_valid_i && req_ready_o;

    // Memory data goes straight back, so a stalled response also holds off the memory
    assign mem_rsp_ready_o = (state_q == st_wait_mem) && rsp_ready_i;
    assign rsp_valid_o     = (state_q == st_respond) ||
                             ((state_q == st_wait_mem) && mem_rsp_valid_i);

    always_comb begin
        rsp_o.id = id_q;
        if (state_q == st_respond) begin
            rsp_o.rdata = DATA_W'(1);
        end else if (we_q) begin
            rsp_o.rdata = '0;
        end else begin
            rsp_o.rdata = mem_rsp_i.rdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= st_idle;
            res_valid_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= sc_fail ? st_respond : st_wait_mem;
                    end
                end
                st_wait_mem: begin
                    if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    if (rsp_ready_i) begin
                        state_q <= st_idle;
                    end
                end
            endcase
            if (accept) begin
                // A store or a successful SC kills every reservation on its word
                for (int i = 0; i < NUM_IDS; i++) begin
                    if (is_write && !sc_fail && res_addr_q[i] == req_word) begin
                        res_valid_q[i] <= 1'b0;
                    end
                end
                if (req_i.op == op_lr) begin
                    res_valid_q[req_i.id] <= 1'b1;
                end
                if (req_i.op == op_sc) begin
                    res_valid_q[req_i.id] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_q <= req_i.id;
            we_q <= is_write;
            if (req_i.op == op_lr) begin
                res_addr_q[req_i.id] <= req_word;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        (mem_req_valid_o && mem_req_ready_i) |=> !mem_req_valid_o);

endmodule

// File: rtl/riscv_atomics_top.sv
// ##########################################################
// Atomics adapter top level
//   AMO sequencer, chain of register cuts, reservation table
// ##########################################################
module riscv_atomics_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  atomics_pkg::bus_req_t req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output atomics_pkg::bus_rsp_t rsp_o,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output atomics_pkg::mem_req_t mem_req_o,
    output logic                  mem_req_valid_o,
    input  logic                  mem_req_ready_i,
    input  atomics_pkg::mem_rsp_t mem_rsp_i,
    input  logic                  mem_rsp_valid_i,
    output logic                  mem_rsp_ready_o
);
    import atomics_pkg::*;

    // Link 0 leaves the sequencer and link N_CUTS enters the reservation table
    bus_req_t req_link       [N_CUTS+1];
    logic     req_link_valid [N_CUTS+1];
    logic     req_link_ready [N_CUTS+1];
    bus_rsp_t rsp_link       [N_CUTS+1];
    logic     rsp_link_valid [N_CUTS+1];
    logic     rsp_link_ready [N_CUTS+1];

    amo_sequencer i_amo_sequencer (
        .clk_i           ( clk_i             ),
        .reset_i         ( reset_i           ),
        .req_i           ( req_i             ),
        .req_valid_i     ( req_valid_i       ),
        .req_ready_o     ( req_ready_o       ),
        .rsp_o           ( rsp_o             ),
        .rsp_valid_o     ( rsp_valid_o       ),
        .rsp_ready_i     ( rsp_ready_i       ),
        .fwd_req_o       ( req_link[0]       ),
        .fwd_req_valid_o ( req_link_valid[0] ),
        .fwd_req_ready_i ( req_link_ready[0] ),
        .fwd_rsp_i       ( rsp_link[0]       ),
        .fwd_rsp_valid_i ( rsp_link_valid[0] ),
        .fwd_rsp_ready_o ( rsp_link_ready[0] )
    );

    for (genvar g = 0; g < N_CUTS; g++) begin : g_cut
        bus_cut i_bus_cut (
            .clk_i           ( clk_i               ),
            .reset_i         ( reset_i             ),
            .in_req_i        ( req_link[g]         ),
            .in_req_valid_i  ( req_link_valid[g]   ),
            .in_req_ready_o  ( req_link_ready[g]   ),
            .out_req_o       ( req_link[g+1]       ),
            .out_req_valid_o ( req_link_valid[g+1] ),
            .out_req_ready_i ( req_link_ready[g+1] ),
            .out_rsp_i       ( rsp_link[g+1]       ),
            .out_rsp_valid_i ( rsp_link_valid[g+1] ),
            .out_rsp_ready_o ( rsp_link_ready[g+1] ),
            .in_rsp_o        ( rsp_link[g]         ),
            .in_rsp_valid_o  ( rsp_link_valid[g]   ),
            .in_rsp_ready_i  ( rsp_link_ready[g]   )
        );
    end

    reservation_table i_reservation_table (
        .clk_i           ( clk_i                  ),
        .reset_i         ( reset_i                ),
        .req_i           ( req_link[N_CUTS]       ),
        .req_valid_i     ( req_link_valid[N_CUTS] ),
        .req_ready_o     ( req_link_ready[N_CUTS] ),
        .rsp_o           ( rsp_link[N_CUTS]       ),
        .rsp_valid_o     ( rsp_link_valid[N_CUTS] ),
        .rsp_ready_i     ( rsp_link_ready[N_CUTS] ),
        .mem_req_o       ( mem_req_o              ),
        .mem_req_valid_o ( mem_req_valid_o        ),
        .mem_req_ready_i ( mem_req_ready_i        ),
        .mem_rsp_i       ( mem_rsp_i              ),
        .mem_rsp_valid_i ( mem_rsp_valid_i        ),
        .mem_rsp_ready_o ( mem_rsp_ready_o        )
    );

endmodule

// File: test/mem_responder.sv
// ##########################################################
// Testbench word memory
//   256 words, cleared on reset
//   Answers each request after a random delay of 0 to 3 cycles
// ##########################################################
module mem_responder (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  atomics_pkg::mem_req_t mem_req_i,
    input  logic                  mem_req_valid_i,
    output logic                  mem_req_ready_o,
    output atomics_pkg::mem_rsp_t mem_rsp_o,
    output logic                  mem_rsp_valid_o,
    input  logic                  mem_rsp_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import atomics_pkg::*;

    logic [DATA_W-1:0] mem_q [256];
    logic              busy_q;
    logic [1:0]        delay_q;

    assign mem_req_ready_o = !busy_q;

    initial begin
        busy_q          = 1'b0;
        delay_q         = 2'd0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_o       = '0;
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            busy_q          <= 1'b0;
            mem_rsp_valid_o <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem_q[i] <= '0;
            end
        end else if (!busy_q) begin
            if (mem_req_valid_i) begin
                busy_q          <= 1'b1;
                delay_q         <= 2'($urandom_range(3, 0));
                mem_rsp_o.rdata <= mem_q[mem_req_i.addr[9:2]];
                if (mem_req_i.we) begin
                    mem_q[mem_req_i.addr[9:2]] <= mem_req_i.wdata;
                end
            end
        end else if (mem_rsp_valid_o) begin
            // Data stays put until the DUT takes it
            if (mem_rsp_ready_i) begin
                busy_q          <= 1'b0;
                mem_rsp_valid_o <= 1'b0;
            end
        end else if (delay_q == 2'd0) begin
            mem_rsp_valid_o <= 1'b1;
        end else begin
            delay_q <= delay_q - 2'd1;
        end
    end

endmodule

// File: test/atomics_tb.sv
// ##########################################################
// Testbench of the atomics adapter
//   Stimulus table of loads, stores, LR/SC and AMOs
//   Second table pass with random response back-pressure
// ##########################################################
module atomics_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import atomics_pkg::*;

    typedef struct packed {
        bus_op_e           op;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] exp;
    } stim_t;

    localparam int unsigned SEED    = 32'he714c066;
    localparam int          TIMEOUT = 200;
    localparam int          N_STIM  = 26;

    // Each AMO returns the word left behind by the one before it
    localparam stim_t STIM [N_STIM] = '{
        '{op_store,    2'd0, 16'h0010, 32'h1234_5678, 32'h0000_0000},
        '{op_load,     2'd1, 16'h0010, 32'h0000_0000, 32'h1234_5678},
        '{op_store,    2'd0, 16'h0020, 32'h0000_000f, 32'h0000_0000},
        '{op_amo_add,  2'd1, 16'h0020, 32'h0000_0001, 32'h0000_000f},
        '{op_amo_swap, 2'd2, 16'h0020, 32'hf0f0_0000, 32'h0000_0010},
        '{op_amo_and,  2'd3, 16'h0020, 32'hff00_ff00, 32'hf0f0_0000},
        '{op_amo_or,   2'd0, 16'h0020, 32'h0000_00aa, 32'hf000_0000},
        '{op_amo_xor,  2'd1, 16'h0020, 32'hff00_00ff, 32'hf000_00aa},
        '{op_load,     2'd2, 16'h0020, 32'h0000_0000, 32'h0f00_0055},
        '{op_store,    2'd0, 16'h0030, 32'h8000_0005, 32'h0000_0000},
        '{op_amo_max,  2'd1, 16'h0030, 32'h0000_0007, 32'h8000_0005},
        '{op_amo_min,  2'd2, 16'h0030, 32'hffff_fffe, 32'h0000_0007},
        '{op_amo_maxu, 2'd3, 16'h0030, 32'h7fff_ffff, 32'hffff_fffe},
        '{op_amo_minu, 2'd0, 16'h0030, 32'h0000_0003, 32'hffff_fffe},
        '{op_load,     2'd1, 16'h0030, 32'h0000_0000, 32'h0000_0003},
        '{op_store,    2'd2, 16'h0040, 32'h0000_0100, 32'h0000_0000},
        '{op_lr,       2'd1, 16'h0040, 32'h0000_0000, 32'h0000_0100},
        '{op_sc,       2'd1, 16'h0040, 32'hcafe_0001, 32'h0000_0000},
        '{op_load,     2'd0, 16'h0040, 32'h0000_0000, 32'hcafe_0001},
        '{op_sc,       2'd2, 16'h0040, 32'h1111_1111, 32'h0000_0001},
        '{op_load,     2'd2, 16'h0040, 32'h0000_0000, 32'hcafe_0001},
        '{op_sc,       2'd1, 16'h0040, 32'h2222_2222, 32'h0000_0001},
        '{op_lr,       2'd3, 16'h0050, 32'h0000_0000, 32'h0000_0000},
        '{op_store,    2'd0, 16'h0050, 32'h5555_aaaa, 32'h0000_0000},
        '{op_sc,       2'd3, 16'h0050, 32'h3333_3333, 32'h0000_0001},
        '{op_load,     2'd1, 16'h0050, 32'h0000_0000, 32'h5555_aaaa}
    };

    logic     clk;
    logic     reset;
    bus_req_t req;
    logic     req_valid;
    logic     req_ready;
    bus_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;
    logic     mem_rsp_ready;

    always #20 clk = !clk;

    riscv_atomics_top i_dut (
        .clk_i           ( clk           ),
        .reset_i         ( reset         ),
        .req_i           ( req           ),
        .req_valid_i     ( req_valid     ),
        .req_ready_o     ( req_ready     ),
        .rsp_o           ( rsp           ),
        .rsp_valid_o     ( rsp_valid     ),
        .rsp_ready_i     ( rsp_ready     ),
        .mem_req_o       ( mem_req       ),
        .mem_req_valid_o ( mem_req_valid ),
        .mem_req_ready_i ( mem_req_ready ),
        .mem_rsp_i       ( mem_rsp       ),
        .mem_rsp_valid_i ( mem_rsp_valid ),
        .mem_rsp_ready_o ( mem_rsp_ready )
    );

    mem_responder i_mem (
        .clk_i           ( clk           ),
        .reset_i         ( reset         ),
        .mem_req_i       ( mem_req       ),
        .mem_req_valid_i ( mem_req_valid ),
        .mem_req_ready_o ( mem_req_ready ),
        .mem_rsp_o       ( mem_rsp       ),
        .mem_rsp_valid_o ( mem_rsp_valid ),
        .mem_rsp_ready_i ( mem_rsp_ready )
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("[FAIL] %s expected %0h got %0h", name, expected, actual));
        end
    endtask

    task automatic send_request(input stim_t s);
        int waited;
        waited = 0;
        req       <= '{addr: s.addr, id: s.id, op: s.op, wdata: s.wdata};
        req_valid <= 1'b1;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("Timed out waiting for the DUT to accept a request");
            end
        end while (!req_ready);
        req_valid <= 1'b0;
    endtask

    // Waits for the response and checks that a stalled response does not move
    task automatic await_response(input logic stall, output bus_rsp_t got);
        int       waited;
        logic     held;
        logic     done;
        bus_rsp_t held_rsp;
        waited   = 0;
        held     = 1'b0;
        done     = 1'b0;
        held_rsp = '0;
        while (!done) begin
            @(posedge clk);
            waited++;
            if (held) begin
                check_value("rsp_valid_o", 64'(1), 64'(rsp_valid));
                check_value("rsp_o", 64'(held_rsp), 64'(rsp));
            end
            if (rsp_valid && rsp_ready) begin
                got  = rsp;
                done = 1'b1;
            end else if (waited > TIMEOUT) begin
                stop_run("Timed out waiting for a response from the DUT");
            end else begin
                held     = rsp_valid;
                held_rsp = rsp;
            end
            if (stall) begin
                rsp_ready <= ($urandom_range(2, 0) == 0);
            end
        end
    endtask

    task automatic run_pass(input logic stall);
        bus_rsp_t got;
        reset     <= 1'b1;
        rsp_ready <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < N_STIM; n++) begin
            send_request(STIM[n]);
            await_response(stall, got);
            check_value("rsp_o.rdata", 64'(STIM[n].exp), 64'(got.rdata));
            check_value("rsp_o.id", 64'(STIM[n].id), 64'(got.id));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk       = 1'b0;
        reset     = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        run_pass(1'b0);
        run_pass(1'b1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: riscv_atomics_top.f
rtl/atomics_pkg.sv
rtl/amo_sequencer.sv
rtl/bus_cut.sv
rtl/reservation_table.sv
rtl/riscv_atomics_top.sv
test/mem_responder.sv
test/atomics_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status gives the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module atomics_tb \
    -f riscv_atomics_top.f -Mdir obj_dir &&
./obj_dir/Vatomics_tb || exit 1
